// ==== hdl/audio_pkg.sv ====
// Audio back end shared definitions
package audio_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int CHIP_W      = 24;  // One chipset channel
  localparam int SAMPLE_W    = 16;  // One mixed or aux channel

  // Low bits dropped on the way from chipset to sample width
  localparam int ROUND_SHIFT = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Aux sample pacing, all in clk_114 cycles
  ////////////////////////////////////////////////////////////////////////////

  // 643 cycles of the 28 MHz clock, four clk_114 cycles each
  localparam int TICK_PERIOD = 643 * 4;
  localparam int TICK_LEN    = 4;   // Window open time
  localparam int TICK_CNT_W  = 12;  // Holds TICK_PERIOD-1

  ////////////////////////////////////////////////////////////////////////////
  // Stereo types
  ////////////////////////////////////////////////////////////////////////////

  // Raw chipset output, left in the upper half
  typedef struct packed {
    logic signed [CHIP_W-1:0] left;
    logic signed [CHIP_W-1:0] right;
  } chip_stereo_t;

  // 16-bit stereo, used for converted, aux and mixed audio
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] left;
    logic signed [SAMPLE_W-1:0] right;
  } stereo_t;

  // Which aux channel takes the stream word
  typedef enum logic [0:0] {
    AUX_RIGHT = 1'b0,  // Window closed
    AUX_LEFT  = 1'b1   // Window open
  } aux_phase_t;

endpackage

// ==== hdl/chip_audio_conv.sv ====
// Chipset audio width reduction
`timescale 1ns/1ps

module chip_audio_conv (
  input  logic                    clk_114,
  input  logic                    rst_n,
  input  audio_pkg::chip_stereo_t chip,
  output audio_pkg::stereo_t      chip16
);

  // One guard bit on top of the chipset width for the rounding add
  localparam int SUM_W = audio_pkg::CHIP_W + 1;
  localparam int SHR_W = SUM_W - audio_pkg::ROUND_SHIFT;

  // Rounding half of the dropped bits
  localparam logic [SUM_W-1:0] HALF_LSB = SUM_W'(1) << (audio_pkg::ROUND_SHIFT - 1);

  // Largest positive 16-bit sample
  localparam logic [audio_pkg::SAMPLE_W-1:0] POS_MAX =
    {1'b0, {(audio_pkg::SAMPLE_W - 1){1'b1}}};

  ////////////////////////////////////////////////////////////////////////////
  // Round to nearest, then clamp positive overflow
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [audio_pkg::SAMPLE_W-1:0] round_sat(
    input logic [audio_pkg::CHIP_W-1:0] x
  );
    logic [SUM_W-1:0] sum;
    logic [SHR_W-1:0] shr;
    sum = {x[audio_pkg::CHIP_W-1], x} + HALF_LSB;  // Sign extended
    shr = sum[SUM_W-1:audio_pkg::ROUND_SHIFT];      // Arithmetic shift
    // Only the positive side can leave the range.
    // The most negative input rounds to exactly -32768.
    if (!shr[SHR_W-1] && shr[SHR_W-2]) begin
      round_sat = POS_MAX;
    end else begin
      round_sat = shr[audio_pkg::SAMPLE_W-1:0];
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      chip16 <= '0;
    end else begin
      chip16.left  <= round_sat(chip.left);
      chip16.right <= round_sat(chip.right);
    end
  end

endmodule

// ==== hdl/aux_sample_pacer.sv ====
// Auxiliary audio sample pacer
`timescale 1ns/1ps

module aux_sample_pacer (
  input  logic                          clk_114,
  input  logic                          rst_n,
  input  logic                          aux_ena,
  input  logic [audio_pkg::SAMPLE_W-1:0] aux_sample,
  output logic                          sample_req,
  output audio_pkg::stereo_t            aux
);

  localparam int HALF_W = audio_pkg::SAMPLE_W / 2;

  localparam logic [audio_pkg::TICK_CNT_W-1:0] CNT_LAST =
    audio_pkg::TICK_CNT_W'(audio_pkg::TICK_PERIOD - 1);
  localparam logic [audio_pkg::TICK_CNT_W-1:0] CNT_LEN =
    audio_pkg::TICK_CNT_W'(audio_pkg::TICK_LEN);

  logic [audio_pkg::TICK_CNT_W-1:0] tick_cnt;
  logic                             tick;
  audio_pkg::aux_phase_t            phase;
  logic [audio_pkg::SAMPLE_W-1:0]   swapped;
  logic                             run;

  // Pacer is held cleared while the aux path is off
  assign run = rst_n & aux_ena;

  // Stream words arrive little endian
  assign swapped = {aux_sample[HALF_W-1:0], aux_sample[audio_pkg::SAMPLE_W-1:HALF_W]};

  ////////////////////////////////////////////////////////////////////////////
  // Tick generation
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (!run) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else begin
      if (tick_cnt == CNT_LAST) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      tick <= (tick_cnt < CNT_LEN);  // Open for the first TICK_LEN counts
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Phase and request
  //
  //   tick       0 1 1 1 1 0 0
  //   phase      R R L L L L R
  //   sample_req 0 0 1 0 0 0 1
  //
  // The request rises on the cycle the phase changes, so the next
  // stream word is visible from the second cycle of each phase.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (!run) begin
      phase      <= audio_pkg::AUX_RIGHT;
      sample_req <= 1'b0;
    end else begin
      phase      <= tick ? audio_pkg::AUX_LEFT : audio_pkg::AUX_RIGHT;
      sample_req <= tick ^ (phase == audio_pkg::AUX_LEFT);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Channel capture
  ////////////////////////////////////////////////////////////////////////////

  // Each register keeps tracking the stream head while its phase lasts,
  // so it ends up with the word that followed the request
  always_ff @(posedge clk_114) begin
    if (!run) begin
      aux <= '0;
    end else if (phase == audio_pkg::AUX_LEFT) begin
      aux.left <= swapped;
    end else begin
      aux.right <= swapped;
    end
  end

endmodule

// ==== hdl/sd_channel.sv ====
// First-order sigma-delta channel
`timescale 1ns/1ps

module sd_channel (
  input  logic                          clk_114,
  input  logic                          rst_n,
  input  logic [audio_pkg::SAMPLE_W-1:0] level,  // Offset binary
  output logic                          bit_out
);

  logic [audio_pkg::SAMPLE_W-1:0] acc;
  logic [audio_pkg::SAMPLE_W:0]   sum;  // Carry on top

  // Accumulator wraps modulo 2^16, carry density is level / 65536
  assign sum = {1'b0, acc} + {1'b0, level};

  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      acc     <= '0;
      bit_out <= 1'b0;
    end else begin
      acc     <= sum[audio_pkg::SAMPLE_W-1:0];
      bit_out <= sum[audio_pkg::SAMPLE_W];
    end
  end

endmodule

// ==== hdl/audio_mix_dac.sv ====
// Chipset and aux audio mixer with DAC
`timescale 1ns/1ps

module audio_mix_dac (
  input  logic               clk_114,
  input  logic               rst_n,
  input  audio_pkg::stereo_t chip16,
  input  audio_pkg::stereo_t aux,
  output audio_pkg::stereo_t mix,
  output logic               audio_l,
  output logic               audio_r
);

  localparam int W = audio_pkg::SAMPLE_W;

  localparam logic [W-1:0] POS_MAX = {1'b0, {(W - 1){1'b1}}};
  localparam logic [W-1:0] NEG_MAX = {1'b1, {(W - 1){1'b0}}};

  logic [W-1:0] level_l;
  logic [W-1:0] level_r;

  ////////////////////////////////////////////////////////////////////////////
  // Saturating add
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [W-1:0] sat_add(
    input logic [W-1:0] a,
    input logic [W-1:0] b
  );
    logic [W:0] sum;
    sum = {a[W-1], a} + {b[W-1], b};
    if (sum[W] != sum[W-1]) begin
      sat_add = sum[W] ? NEG_MAX : POS_MAX;  // Clip toward the true sign
    end else begin
      sat_add = sum[W-1:0];
    end
  endfunction

  // Mixed sample, also the parallel output
  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      mix <= '0;
    end else begin
      mix.left  <= sat_add(chip16.left, aux.left);
      mix.right <= sat_add(chip16.right, aux.right);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // DAC
  ////////////////////////////////////////////////////////////////////////////

  // Two's complement to offset binary
  assign level_l = {~mix.left[W-1], mix.left[W-2:0]};
  assign level_r = {~mix.right[W-1], mix.right[W-2:0]};

  sd_channel i_sd_l (
    .clk_114 (clk_114),
    .rst_n   (rst_n),
    .level   (level_l),
    .bit_out (audio_l)
  );

  sd_channel i_sd_r (
    .clk_114 (clk_114),
    .rst_n   (rst_n),
    .level   (level_r),
    .bit_out (audio_r)
  );

endmodule

// ==== hdl/audio_out_top.sv ====
// Audio output top level
`timescale 1ns/1ps

module audio_out_top (
  input  logic                          clk_114,
  input  logic                          rst_n,
  input  logic                          aux_ena,
  input  audio_pkg::chip_stereo_t       chip,
  input  logic [audio_pkg::SAMPLE_W-1:0] aux_sample,
  output logic                          sample_req,
  output audio_pkg::stereo_t            mix,
  output logic                          audio_l,
  output logic                          audio_r
);

  audio_pkg::stereo_t chip16;  // Converted chipset audio
  audio_pkg::stereo_t aux;     // Paced stream audio

  ////////////////////////////////////////////////////////////////////////////
  // Chipset path
  ////////////////////////////////////////////////////////////////////////////

  chip_audio_conv i_conv (
    .clk_114 (clk_114),
    .rst_n   (rst_n),
    .chip    (chip),
    .chip16  (chip16)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Aux path
  ////////////////////////////////////////////////////////////////////////////

  aux_sample_pacer i_pacer (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .aux_ena    (aux_ena),
    .aux_sample (aux_sample),
    .sample_req (sample_req),  // One word per pulse
    .aux        (aux)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Mixer and DAC
  ////////////////////////////////////////////////////////////////////////////

  audio_mix_dac i_mix_dac (
    .clk_114 (clk_114),
    .rst_n   (rst_n),
    .chip16  (chip16),
    .aux     (aux),
    .mix     (mix),
    .audio_l (audio_l),
    .audio_r (audio_r)
  );

endmodule

// ==== sim/audio_out_chk.sv ====
// Audio top level protocol checks
`timescale 1ns/1ps

module audio_out_chk (
  input logic clk_114,
  input logic rst_n,
  input logic aux_ena,
  input logic sample_req,
  input logic audio_l,
  input logic audio_r
);

  int fail_count = 0;

  // Window state as seen from the request pulses
  audio_pkg::aux_phase_t req_phase;

  always_ff @(posedge clk_114) begin
    if (!rst_n || !aux_ena) begin
      req_phase <= audio_pkg::AUX_RIGHT;
    end else if (sample_req) begin
      req_phase <= (req_phase == audio_pkg::AUX_LEFT) ?
                   audio_pkg::AUX_RIGHT : audio_pkg::AUX_LEFT;
    end
  end

  single_pulse: assert property (@(posedge clk_114) sample_req |=> !sample_req)
    else begin
      fail_count++;
      $error("sample_req high on two cycles in a row");
    end

  // Quiet in reset and on the first cycle out of it
  reset_quiet: assert property (@(posedge clk_114) !rst_n |=> !sample_req ##1 !sample_req)
    else begin
      fail_count++;
      $error("sample_req pulsed during or right after reset");
    end

  pair_spacing: assert property (@(posedge clk_114) disable iff (!rst_n || !aux_ena)
    (sample_req && req_phase == audio_pkg::AUX_RIGHT) |-> ##(audio_pkg::TICK_LEN) sample_req)
    else begin
      fail_count++;
      $error("closing request not TICK_LEN cycles after the opening one");
    end

  dac_known: assert property (@(posedge clk_114) disable iff (!rst_n)
    !$isunknown({audio_l, audio_r}))
    else begin
      fail_count++;
      $error("DAC output unknown");
    end

endmodule

bind audio_out_top audio_out_chk i_chk (
  .clk_114    (clk_114),
  .rst_n      (rst_n),
  .aux_ena    (aux_ena),
  .sample_req (sample_req),
  .audio_l    (audio_l),
  .audio_r    (audio_r)
);

// ==== sim/audio_out_tb.sv ====
// Audio back end testbench
`timescale 1ns/1ps

module audio_out_tb;

  localparam int W           = audio_pkg::SAMPLE_W;
  localparam int DAC_CYCLES  = 65536;  // One full accumulator cycle
  localparam int CONV_VALUES = 200;
  localparam int PAIRS       = 20;
  localparam int NUM_WORDS   = 64;

  // Three DAC runs and the pacing run, plus the short tests and a margin
  localparam int TIMEOUT_CYCLES =
    3 * DAC_CYCLES + 30 * audio_pkg::TICK_PERIOD + 3 * CONV_VALUES + 1000;

  localparam int MODE_IDLE = 0;
  localparam int MODE_CONV = 1;  // Chip to mix on every cycle
  localparam int MODE_AUX  = 2;  // Compare at each request pulse

  logic                    clk_114;
  logic                    rst_n;
  logic                    aux_ena;
  audio_pkg::chip_stereo_t chip;
  logic [W-1:0]            aux_sample;
  logic                    sample_req;
  audio_pkg::stereo_t      mix;
  logic                    audio_l;
  logic                    audio_r;

  logic [31:0] rng;
  int          errors = 0;
  int          checks = 0;
  int          mode = MODE_IDLE;

  // Outside sample stream
  logic [W-1:0] words [NUM_WORDS];
  int           word_idx = 0;
  logic         req_seen = 1'b0;

  // Compare process state
  int                      cycle = 0;
  int                      hist = 0;
  audio_pkg::chip_stereo_t chip_d1;
  audio_pkg::chip_stereo_t chip_d2;
  logic                    next_open = 1'b1;
  int                      opens = 0;
  int                      closes = 0;
  int                      last_open = 0;

  assign aux_sample = words[word_idx];  // Head of the stream

  audio_out_top i_dut (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .aux_ena    (aux_ena),
    .chip       (chip),
    .aux_sample (aux_sample),
    .sample_req (sample_req),
    .mix        (mix),
    .audio_l    (audio_l),
    .audio_r    (audio_r)
  );

  initial clk_114 = 1'b0;
  always #5 clk_114 = ~clk_114;  // 10 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Mostly random, often right at full scale
  function automatic logic [23:0] chip_value(input logic [31:0] r);
    case (r[27:24])
      4'd0:    chip_value = 24'h7fffff;
      4'd1:    chip_value = 24'h7fff80;  // Rounds past the top
      4'd2:    chip_value = 24'h800000;
      4'd3:    chip_value = 24'h800080;
      4'd4:    chip_value = 24'h7fff7f;
      4'd5:    chip_value = 24'hffff80;
      default: chip_value = r[23:0];
    endcase
  endfunction

  function automatic logic [W-1:0] stream_word(input logic [31:0] r);
    if (r[29:28] == 2'd0) begin
      stream_word = r[0] ? 16'h0080 : 16'hff7f;  // Full scale once swapped
    end else begin
      stream_word = r[15:0];
    end
  endfunction

  function automatic logic signed [W-1:0] round_sat(input logic signed [23:0] x);
    int v;
    v = x;
    v = (v + (1 << (audio_pkg::ROUND_SHIFT - 1))) >>> audio_pkg::ROUND_SHIFT;
    if (v > 32767) begin
      v = 32767;
    end
    if (v < -32768) begin
      v = -32768;
    end
    return v[W-1:0];
  endfunction

  function automatic logic [W-1:0] swap_bytes(input logic [W-1:0] w);
    return {w[7:0], w[15:8]};
  endfunction

  function automatic logic signed [W-1:0] mix_sat(input logic [W-1:0] a,
                                                  input logic [W-1:0] b);
    int s;
    s = int'($signed(a)) + int'($signed(b));
    if (s > 32767) begin
      s = 32767;
    end else if (s < -32768) begin
      s = -32768;
    end
    return s[W-1:0];
  endfunction

  function automatic int offset_bin(input logic [W-1:0] m);
    return int'($signed(m)) + 32768;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stream source and compare process
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_114) begin
    req_seen <= sample_req;
  end

  // Next word shows from the cycle after a request
  always @(posedge clk_114) begin
    if (req_seen) begin
      word_idx <= (word_idx + 1) % NUM_WORDS;
    end
  end

  always @(negedge clk_114) begin : compare
    logic [W-1:0] prev;
    logic [W-1:0] exp_aux;
    cycle++;
    prev = words[(word_idx + NUM_WORDS - 1) % NUM_WORDS];  // Word before the head
    if (mode == MODE_CONV) begin
      if (hist >= 2) begin
        check_value("mix.left", mix.left, round_sat(chip_d2.left));
        check_value("mix.right", mix.right, round_sat(chip_d2.right));
      end
      chip_d2 = chip_d1;
      chip_d1 = chip;
      hist++;
    end else begin
      hist = 0;
    end
    if (mode != MODE_AUX) begin
      next_open = 1'b1;
      opens     = 0;
      closes    = 0;
    end else if (sample_req && next_open) begin
      if (opens > 0) begin
        checks++;
        assert (cycle - last_open == audio_pkg::TICK_PERIOD) else begin
          errors++;
          $display("Window opened %0d cycles after the last one, not %0d",
                   cycle - last_open, audio_pkg::TICK_PERIOD);
        end
      end
      exp_aux = (opens == 0) ? '0 : swap_bytes(prev);  // Nothing captured yet
      check_value("mix.left", mix.left, mix_sat(round_sat(chip.left), exp_aux));
      last_open = cycle;
      opens++;
      next_open = 1'b0;
    end else if (sample_req) begin
      checks++;
      assert (cycle - last_open == audio_pkg::TICK_LEN) else begin
        errors++;
        $display("Window closed %0d cycles after opening, not %0d",
                 cycle - last_open, audio_pkg::TICK_LEN);
      end
      check_value("mix.right", mix.right, mix_sat(round_sat(chip.right), swap_bytes(prev)));
      closes++;
      next_open = 1'b1;
    end
  end

  // Ones over one accumulator cycle at a constant level
  task automatic dac_density(input logic [23:0] cl, input logic [23:0] cr);
    audio_pkg::stereo_t exp_mix;
    int                 ones_l;
    int                 ones_r;
    int                 n;
    @(posedge clk_114);
    chip.left     <= cl;
    chip.right    <= cr;
    exp_mix.left  = round_sat(cl);
    exp_mix.right = round_sat(cr);
    n = 0;
    @(negedge clk_114);
    while (mix != exp_mix && n < 8) begin
      @(negedge clk_114);
      n++;
    end
    check_value("mix.left", mix.left, exp_mix.left);
    check_value("mix.right", mix.right, exp_mix.right);
    ones_l = 0;
    ones_r = 0;
    repeat (DAC_CYCLES) begin
      @(negedge clk_114);
      if (audio_l) begin
        ones_l++;
      end
      if (audio_r) begin
        ones_r++;
      end
    end
    check_value("audio_l ones", ones_l, offset_bin(exp_mix.left));
    check_value("audio_r ones", ones_r, offset_bin(exp_mix.right));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    rst_n   = 1'b0;
    aux_ena = 1'b0;
    chip    = '0;
    rng     = 32'd83760;
    for (int i = 0; i < NUM_WORDS; i++) begin
      rng      = xorshift(rng);
      words[i] = stream_word(rng);
    end

    repeat (5) @(posedge clk_114);
    rst_n <= 1'b1;
    @(posedge clk_114);
    @(negedge clk_114);
    check_value("sample_req", sample_req, 0);
    check_value("audio_l", audio_l, 0);
    check_value("audio_r", audio_r, 0);
    check_value("mix", mix, 0);

    // Chipset conversion with the aux path off
    @(posedge clk_114);
    mode <= MODE_CONV;
    for (int i = 0; i < CONV_VALUES; i++) begin
      rng = xorshift(rng);
      chip.left <= chip_value(rng);
      rng = xorshift(rng);
      chip.right <= chip_value(rng);
      repeat (3) @(posedge clk_114);
    end
    mode <= MODE_IDLE;

    dac_density(24'h800000, 24'h7fffff);
    dac_density(24'h7fffff, 24'h800000);
    rng = xorshift(rng);
    dac_density(rng[23:0], rng[31:8]);

    // Pacing and aux capture with a new chip value after every pair
    @(posedge clk_114);
    rng = xorshift(rng);
    chip.left <= rng[23:0];
    rng = xorshift(rng);
    chip.right <= rng[23:0];
    aux_ena    <= 1'b1;
    mode       <= MODE_AUX;
    for (int p = 0; p < PAIRS; p++) begin
      while (closes <= p) begin
        @(posedge clk_114);
      end
      rng = xorshift(rng);
      chip.left <= rng[23:0];
      rng = xorshift(rng);
      chip.right <= rng[23:0];
    end
    @(posedge clk_114);
    aux_ena <= 1'b0;
    mode    <= MODE_IDLE;
    repeat (10) @(posedge clk_114);

    errors += i_dut.i_chk.fail_count;
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_114);
    $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/audio_pkg.sv
hdl/chip_audio_conv.sv
hdl/aux_sample_pacer.sv
hdl/sd_channel.sv
hdl/audio_mix_dac.sv
hdl/audio_out_top.sv
sim/audio_out_chk.sv
sim/audio_out_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module audio_out_tb -f vlog.f
out=$(./obj_dir/Vaudio_out_tb) || true
echo "$out"
echo "$out" | grep -qx "TEST PASS"
